// File: list.f
+incdir+.
dsp_pkg.sv
dsp_cfg_regs.sv
code_history.sv
lane_equalizer.sv
error_builder.sv
datapath_core.sv
tb_datapath_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f list.f \
        --top-module tb_datapath_core --Mdir obj_dir -o sim_tb; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF "** PASS **" <<< "$out"; then
    exit 0
fi
exit 1

// File: tb_datapath_core.sv
`include "dsp_defs.svh"

module tb_datapath_core;

    localparam int N_STREAM = 300;
    localparam int N_GAP    = 200;
    localparam int N_RECFG  = 100;
    // Reset, register traffic and pipeline drains
    localparam int MARGIN   = 1500;
    localparam int LIMIT_T  = (16 + N_STREAM + N_GAP + N_RECFG + MARGIN) * 4;

    logic               clk = 1'b0;
    logic               rst_n_i;
    dsp_pkg::axil_req_t req;
    dsp_pkg::axil_rsp_t rsp;
    dsp_pkg::adc_word_t adc_codes;
    logic               adc_valid;
    dsp_pkg::bit_word_t bits;
    logic               bits_valid;
    dsp_pkg::err_word_t err;
    logic               err_valid;

    // Register shadow and model history
    logic [31:0]        ffe_reg;
    logic [31:0]        ctrl_reg;
    logic [31:0]        chan_reg;
    dsp_pkg::adc_word_t prev_word;
    dsp_pkg::bit_word_t prev_bits;
    dsp_pkg::bit_word_t exp_bits [$];
    dsp_pkg::err_word_t exp_err [$];
    int                 errors;
    int                 checks;
    int                 tests;
    int                 bits_seen;
    int                 err_seen;

    datapath_core dut_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .axil_req_i   (req),
        .axil_rsp_o   (rsp),
        .adc_codes_i  (adc_codes),
        .adc_valid_i  (adc_valid),
        .bits_o       (bits),
        .bits_valid_o (bits_valid),
        .err_o        (err),
        .err_valid_o  (err_valid)
    );

    always #2 clk = ~clk;

    function automatic int sx8(input logic [7:0] v);
        return int'($signed(v));
    endfunction

    task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] got);
        checks++;
        if (got !== exp) begin
            $display("FAIL time %0t %s expected %0h got %0h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %s finished, errors so far %0d", name, errors);
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        req.awaddr  = addr;
        req.wdata   = data;
        req.awvalid = 1'b1;
        req.wvalid  = 1'b1;
        do @(negedge clk); while (!rsp.awready);
        @(posedge clk);
        #1;
        req.awvalid = 1'b0;
        req.wvalid  = 1'b0;
        do @(negedge clk); while (!rsp.bvalid);
        resp = rsp.bresp;
        @(posedge clk);
        #1;
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        req.araddr  = addr;
        req.arvalid = 1'b1;
        do @(negedge clk); while (!rsp.arready);
        @(posedge clk);
        #1;
        req.arvalid = 1'b0;
        do @(negedge clk); while (!rsp.rvalid);
        data = rsp.rdata;
        resp = rsp.rresp;
        @(posedge clk);
        #1;
    endtask

    // Random weights and channel, moderate shifts and a small threshold
    task automatic configure();
        logic [1:0] resp;
        ffe_reg  = $urandom;
        ctrl_reg = {16'h0, 4'($urandom % 4), 4'($urandom % 8), 8'($urandom % 64) - 8'd32};
        chan_reg = $urandom;
        axi_write(`DSP_ADDR_FFE, ffe_reg, resp);
        compare("bresp", 2'b00, resp);
        axi_write(`DSP_ADDR_CTRL, ctrl_reg, resp);
        compare("bresp", 2'b00, resp);
        axi_write(`DSP_ADDR_CHAN, chan_reg, resp);
        compare("bresp", 2'b00, resp);
    endtask

    // FFE, slicer and channel filter applied to one valid word
    task automatic predict(input dsp_pkg::adc_word_t w);
        dsp_pkg::bit_word_t b;
        dsp_pkg::err_word_t e;
        int acc;
        int pos;
        int c;
        int t;
        for (int ln = 0; ln < `DSP_LANES; ln++) begin
            acc = 0;
            for (int k = 0; k < `DSP_FFE_TAPS; k++) begin
                pos = ln - k;
                if (pos < 0)
                    c = sx8(prev_word[pos + `DSP_LANES]);
                else
                    c = sx8(w[pos]);
                acc += c * sx8(ffe_reg[8*k +: 8]);
            end
            b[ln] = (acc >>> ctrl_reg[11:8]) >= sx8(ctrl_reg[7:0]);
        end
        for (int ln = 0; ln < `DSP_LANES; ln++) begin
            acc = 0;
            for (int k = 0; k < `DSP_CHAN_TAPS; k++) begin
                pos = ln - k;
                t   = sx8(chan_reg[8*k +: 8]);
                if (pos < 0)
                    acc += prev_bits[pos + `DSP_LANES] ? t : -t;
                else
                    acc += b[pos] ? t : -t;
            end
            e[ln] = dsp_pkg::err_t'((acc >>> ctrl_reg[15:12]) - sx8(w[ln]));
        end
        prev_word = w;
        prev_bits = b;
        exp_bits.push_back(b);
        exp_err.push_back(e);
    endtask

    task automatic stream(input string name, input int n, input int idle_pct);
        dsp_pkg::adc_word_t w;
        int sent;
        int bits0;
        int err0;
        sent  = 0;
        bits0 = bits_seen;
        err0  = err_seen;
        for (int i = 0; i < n; i++) begin
            w = $urandom;
            adc_codes = w;
            if ($urandom % 100 < idle_pct) begin
                adc_valid = 1'b0;
            end else begin
                adc_valid = 1'b1;
                predict(w);
                sent++;
            end
            @(posedge clk);
            #1;
        end
        adc_valid = 1'b0;
        // Three register stages, then some slack
        repeat (6) @(posedge clk);
        #1;
        compare("bits_valid_o count", sent, bits_seen - bits0);
        compare("err_valid_o count", sent, err_seen - err0);
        if (exp_bits.size() != 0 || exp_err.size() != 0) begin
            $display("words still expected at the end of %s", name);
            errors++;
        end
        finish_test(name);
    endtask

    always @(negedge clk) begin
        if (rst_n_i && bits_valid) begin
            bits_seen++;
            if (exp_bits.size() == 0) begin
                $display("bits_valid_o high at %0t with no word outstanding", $time);
                errors++;
            end else begin
                compare("bits_o", exp_bits.pop_front(), bits);
            end
        end
        if (rst_n_i && err_valid) begin
            err_seen++;
            if (exp_err.size() == 0) begin
                $display("err_valid_o high at %0t with no word outstanding", $time);
                errors++;
            end else begin
                compare("err_o", exp_err.pop_front(), err);
            end
        end
    end

    initial begin
        #(LIMIT_T);
        $display("timeout, the run did not finish in %0d time units", LIMIT_T);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        logic [31:0] rd;
        logic [1:0]  resp;
        logic [31:0] wv [3];
        void'($urandom(32'hb17c2f25));
        rst_n_i     = 1'b0;
        req         = '0;
        req.bready  = 1'b1;
        req.rready  = 1'b1;
        adc_codes   = '0;
        adc_valid   = 1'b0;
        ffe_reg     = '0;
        ctrl_reg    = '0;
        chan_reg    = '0;
        prev_word   = '0;
        prev_bits   = '0;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        bits_seen   = 0;
        err_seen    = 0;
        repeat (16) @(posedge clk);
        #1;
        rst_n_i = 1'b1;

        compare("bits_valid_o", 1'b0, bits_valid);
        compare("err_valid_o", 1'b0, err_valid);
        compare("bvalid", 1'b0, rsp.bvalid);
        compare("rvalid", 1'b0, rsp.rvalid);
        for (int a = 0; a < 3; a++) begin
            axi_read(4'(4 * a), rd, resp);
            compare("rdata", 32'h0, rd);
            compare("rresp", 2'b00, resp);
        end
        finish_test("reset state");

        for (int a = 0; a < 3; a++) begin
            wv[a] = $urandom;
            axi_write(4'(4 * a), wv[a], resp);
            compare("bresp", 2'b00, resp);
        end
        for (int a = 0; a < 3; a++) begin
            axi_read(4'(4 * a), rd, resp);
            compare("rdata", wv[a], rd);
            compare("rresp", 2'b00, resp);
        end
        axi_write(4'hc, $urandom, resp);
        compare("bresp", 2'b10, resp);
        axi_read(4'hc, rd, resp);
        compare("rdata", 32'h0, rd);
        compare("rresp", 2'b10, resp);
        for (int a = 0; a < 3; a++) begin
            axi_read(4'(4 * a), rd, resp);
            compare("rdata", wv[a], rd);
        end
        finish_test("register access");

        configure();
        stream("sliced bits and error", N_STREAM, 0);
        stream("gaps in the stream", N_GAP, 30);
        configure();
        stream("reconfiguration", N_RECFG, 0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: datapath_core.sv
`include "dsp_defs.svh"

module datapath_core (
    input  logic               clk,
    input  logic               rst_n_i,
    input  dsp_pkg::axil_req_t axil_req_i,
    output dsp_pkg::axil_rsp_t axil_rsp_o,
    input  dsp_pkg::adc_word_t adc_codes_i,
    input  logic               adc_valid_i,
    output dsp_pkg::bit_word_t bits_o,
    output logic               bits_valid_o,
    output dsp_pkg::err_word_t err_o,
    output logic               err_valid_o
);

    dsp_pkg::eq_cfg_t        cfg;
    dsp_pkg::adc_word_t      cur_codes;
    dsp_pkg::adc_word_t      prev_codes;
    dsp_pkg::adc_word_t      aligned_codes;
    logic                    cur_valid;
    wire dsp_pkg::bit_word_t lane_bits;
    wire [`DSP_LANES-1:0]    lane_valid;

    dsp_cfg_regs cfg_regs_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .axil_req_i (axil_req_i),
        .axil_rsp_o (axil_rsp_o),
        .cfg_o      (cfg)
    );

    code_history history_i (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .adc_codes_i     (adc_codes_i),
        .adc_valid_i     (adc_valid_i),
        .cur_codes_o     (cur_codes),
        .prev_codes_o    (prev_codes),
        .cur_valid_o     (cur_valid),
        .aligned_codes_o (aligned_codes)
    );

    for (genvar gi = 0; gi < `DSP_LANES; gi++) begin : g_lane
        lane_equalizer #(
            .LANE (gi)
        ) lane_eq_i (
            .clk          (clk),
            .rst_n_i      (rst_n_i),
            .cur_codes_i  (cur_codes),
            .prev_codes_i (prev_codes),
            .valid_i      (cur_valid),
            .cfg_i        (cfg),
            .bit_o        (lane_bits[gi]),
            .valid_o      (lane_valid[gi])
        );
    end

    error_builder err_build_i (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .bits_i          (lane_bits),
        .bits_valid_i    (lane_valid[0]),
        .aligned_codes_i (aligned_codes),
        .cfg_i           (cfg),
        .err_o           (err_o),
        .err_valid_o     (err_valid_o)
    );

    assign bits_o       = lane_bits;
    assign bits_valid_o = lane_valid[0];

endmodule

// File: error_builder.sv
`include "dsp_defs.svh"

module error_builder (
    input  logic               clk,
    input  logic               rst_n_i,
    input  dsp_pkg::bit_word_t bits_i,
    input  logic               bits_valid_i,
    input  dsp_pkg::adc_word_t aligned_codes_i,
    input  dsp_pkg::eq_cfg_t   cfg_i,
    output dsp_pkg::err_word_t err_o,
    output logic               err_valid_o
);

    dsp_pkg::bit_word_t      prev_bits_q;
    wire dsp_pkg::err_word_t err_d;
    dsp_pkg::err_word_t      err_q;
    logic                    valid_q;

    for (genvar ln = 0; ln < `DSP_LANES; ln++) begin : g_lane
        dsp_pkg::err_t term [`DSP_CHAN_TAPS];
        dsp_pkg::err_t sum;
        dsp_pkg::err_t est;

        for (genvar k = 0; k < `DSP_CHAN_TAPS; k++) begin : g_tap
            localparam int POS = ln - k;
            localparam int IDX = (POS < 0) ? POS + `DSP_LANES : POS;

            logic          sym;
            dsp_pkg::err_t tap;

            assign sym     = (POS < 0) ? prev_bits_q[IDX] : bits_i[IDX];
            assign tap     = dsp_pkg::err_t'($signed(cfg_i.chan[k]));
            // Bit 1 is symbol +1, bit 0 is symbol -1
            assign term[k] = sym ? tap : -tap;
        end

        always_comb begin
            sum = '0;
            for (int k = 0; k < `DSP_CHAN_TAPS; k++) begin
                sum = sum + term[k];
            end
        end

        assign est       = sum >>> cfg_i.chan_shift;
        assign err_d[ln] = est - dsp_pkg::err_t'($signed(aligned_codes_i[ln]));
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prev_bits_q <= '0;
            valid_q     <= 1'b0;
        end else begin
            valid_q <= bits_valid_i;
            if (bits_valid_i) begin
                prev_bits_q <= bits_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bits_valid_i) begin
            err_q <= err_d;
        end
    end

    assign err_o       = err_q;
    assign err_valid_o = valid_q;

    a_err_follows: assert property (@(posedge clk) disable iff (!rst_n_i)
        err_valid_o == $past(bits_valid_i));

endmodule

// File: lane_equalizer.sv
`include "dsp_defs.svh"

module lane_equalizer #(
    parameter int LANE = 0
) (
    input  logic               clk,
    input  logic               rst_n_i,
    input  dsp_pkg::adc_word_t cur_codes_i,
    input  dsp_pkg::adc_word_t prev_codes_i,
    input  logic               valid_i,
    input  dsp_pkg::eq_cfg_t   cfg_i,
    output logic               bit_o,
    output logic               valid_o
);

    typedef logic signed [`DSP_FFE_W-1:0] acc_t;

    acc_t prod [`DSP_FFE_TAPS];
    acc_t acc;
    acc_t eq_val;
    logic slice;
    logic bit_q;
    logic valid_q;

    // Tap k looks k samples back, wrapping into the previous word
    for (genvar k = 0; k < `DSP_FFE_TAPS; k++) begin : g_tap
        localparam int POS = LANE - k;
        localparam int IDX = (POS < 0) ? POS + `DSP_LANES : POS;

        dsp_pkg::code_t code;

        assign code    = (POS < 0) ? prev_codes_i[IDX] : cur_codes_i[IDX];
        assign prod[k] = acc_t'($signed(code)) * acc_t'($signed(cfg_i.weights[k]));
    end

    always_comb begin
        acc = '0;
        for (int k = 0; k < `DSP_FFE_TAPS; k++) begin
            acc = acc + prod[k];
        end
    end

    assign eq_val = acc >>> cfg_i.ffe_shift;
    assign slice  = (eq_val >= acc_t'($signed(cfg_i.thresh)));

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            bit_q <= slice;
        end
    end

    assign bit_o   = bit_q;
    assign valid_o = valid_q;

    a_bit_known: assert property (@(posedge clk) disable iff (!rst_n_i)
        valid_o |-> !$isunknown(bit_o));

endmodule

// File: code_history.sv
module code_history (
    input  logic               clk,
    input  logic               rst_n_i,
    input  dsp_pkg::adc_word_t adc_codes_i,
    input  logic               adc_valid_i,
    output dsp_pkg::adc_word_t cur_codes_o,
    output dsp_pkg::adc_word_t prev_codes_o,
    output logic               cur_valid_o,
    output dsp_pkg::adc_word_t aligned_codes_o
);

    dsp_pkg::adc_word_t cur_q;
    dsp_pkg::adc_word_t prev_q;
    dsp_pkg::adc_word_t aligned_q;
    logic               cur_valid_q;

    // History only moves on valid words so gaps do not break the serial order
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cur_q       <= '0;
            prev_q      <= '0;
            cur_valid_q <= 1'b0;
        end else begin
            cur_valid_q <= adc_valid_i;
            if (adc_valid_i) begin
                cur_q  <= adc_codes_i;
                prev_q <= cur_q;
            end
        end
    end

    // Matches the lane register stage
    always_ff @(posedge clk) begin
        aligned_q <= cur_q;
    end

    assign cur_codes_o     = cur_q;
    assign prev_codes_o    = prev_q;
    assign cur_valid_o     = cur_valid_q;
    assign aligned_codes_o = aligned_q;

endmodule

// File: dsp_cfg_regs.sv
`include "dsp_defs.svh"

module dsp_cfg_regs (
    input  logic               clk,
    input  logic               rst_n_i,
    input  dsp_pkg::axil_req_t axil_req_i,
    output dsp_pkg::axil_rsp_t axil_rsp_o,
    output dsp_pkg::eq_cfg_t   cfg_o
);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    dsp_pkg::cfg_word_u ffe_q;
    dsp_pkg::cfg_word_u ctrl_q;
    dsp_pkg::cfg_word_u chan_q;
    dsp_pkg::cfg_word_u rd_word;

    logic                       awready_q;
    logic                       bvalid_q;
    logic [1:0]                 bresp_q;
    logic                       arready_q;
    logic                       rvalid_q;
    logic [1:0]                 rresp_q;
    logic [`DSP_AXI_DATA_W-1:0] rdata_q;
    logic                       wr_start;
    logic                       rd_start;

    function automatic logic addr_known(input logic [`DSP_AXI_ADDR_W-1:0] addr);
        return (addr == `DSP_ADDR_FFE) || (addr == `DSP_ADDR_CTRL) ||
               (addr == `DSP_ADDR_CHAN);
    endfunction

    // One write or read in flight at a time
    assign wr_start = axil_req_i.awvalid && axil_req_i.wvalid && !awready_q && !bvalid_q;
    assign rd_start = axil_req_i.arvalid && !arready_q && !rvalid_q;

    always_comb begin
        case (axil_req_i.araddr)
            `DSP_ADDR_FFE:  rd_word = ffe_q;
            `DSP_ADDR_CTRL: rd_word = ctrl_q;
            `DSP_ADDR_CHAN: rd_word = chan_q;
            default:        rd_word = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            awready_q <= 1'b0;
            bvalid_q  <= 1'b0;
            bresp_q   <= RESP_OKAY;
            arready_q <= 1'b0;
            rvalid_q  <= 1'b0;
            rresp_q   <= RESP_OKAY;
            rdata_q   <= '0;
        end else begin
            awready_q <= wr_start;
            if (awready_q) begin
                bvalid_q <= 1'b1;
                bresp_q  <= addr_known(axil_req_i.awaddr) ? RESP_OKAY : RESP_SLVERR;
            end else if (axil_req_i.bready) begin
                bvalid_q <= 1'b0;
            end

            arready_q <= rd_start;
            if (arready_q) begin
                rvalid_q <= 1'b1;
                rdata_q  <= rd_word;
                rresp_q  <= addr_known(axil_req_i.araddr) ? RESP_OKAY : RESP_SLVERR;
            end else if (axil_req_i.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // Writes to unmapped addresses fall through untouched
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ffe_q  <= '0;
            ctrl_q <= '0;
            chan_q <= '0;
        end else if (awready_q) begin
            case (axil_req_i.awaddr)
                `DSP_ADDR_FFE:  ffe_q  <= axil_req_i.wdata;
                `DSP_ADDR_CTRL: ctrl_q <= axil_req_i.wdata;
                `DSP_ADDR_CHAN: chan_q <= axil_req_i.wdata;
                default: ;
            endcase
        end
    end

    always_comb begin
        cfg_o.weights    = ffe_q.taps[`DSP_FFE_TAPS-1:0];
        cfg_o.thresh     = ctrl_q.ctrl.thresh;
        cfg_o.ffe_shift  = ctrl_q.ctrl.ffe_shift;
        cfg_o.chan       = chan_q.taps[`DSP_CHAN_TAPS-1:0];
        cfg_o.chan_shift = ctrl_q.ctrl.chan_shift;
    end

    always_comb begin
        axil_rsp_o.awready = awready_q;
        axil_rsp_o.wready  = awready_q;
        axil_rsp_o.bresp   = bresp_q;
        axil_rsp_o.bvalid  = bvalid_q;
        axil_rsp_o.arready = arready_q;
        axil_rsp_o.rdata   = rdata_q;
        axil_rsp_o.rresp   = rresp_q;
        axil_rsp_o.rvalid  = rvalid_q;
    end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        bvalid_q && !axil_req_i.bready |=> bvalid_q);

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        rvalid_q && !axil_req_i.rready |=> rvalid_q && $stable(rdata_q));

endmodule

// File: dsp_pkg.sv
`include "dsp_defs.svh"

package dsp_pkg;

    typedef logic signed [`DSP_CODE_W-1:0]   code_t;
    typedef logic signed [`DSP_WEIGHT_W-1:0] weight_t;
    typedef logic signed [`DSP_THRESH_W-1:0] thresh_t;
    typedef logic signed [`DSP_CHAN_W-1:0]   chan_t;
    typedef logic signed [`DSP_ERR_W-1:0]    err_t;
    typedef logic [`DSP_SHIFT_W-1:0]         shift_t;

    // Lane 0 holds the oldest serial sample
    typedef code_t [`DSP_LANES-1:0] adc_word_t;
    typedef logic  [`DSP_LANES-1:0] bit_word_t;
    typedef err_t  [`DSP_LANES-1:0] err_word_t;

    typedef struct packed {
        logic [`DSP_AXI_DATA_W-`DSP_THRESH_W-2*`DSP_SHIFT_W-1:0] rsvd;
        shift_t  chan_shift;
        shift_t  ffe_shift;
        thresh_t thresh;
    } ctrl_fields_t;

    // FFE and channel registers read as signed bytes, control as fields
    typedef union packed {
        weight_t [`DSP_AXI_DATA_W/`DSP_WEIGHT_W-1:0] taps;
        ctrl_fields_t                                ctrl;
    } cfg_word_u;

    typedef struct packed {
        weight_t [`DSP_FFE_TAPS-1:0] weights;
        thresh_t                     thresh;
        shift_t                      ffe_shift;
        chan_t [`DSP_CHAN_TAPS-1:0]  chan;
        shift_t                      chan_shift;
    } eq_cfg_t;

    typedef struct packed {
        logic [`DSP_AXI_ADDR_W-1:0] awaddr;
        logic                       awvalid;
        logic [`DSP_AXI_DATA_W-1:0] wdata;
        logic                       wvalid;
        logic                       bready;
        logic [`DSP_AXI_ADDR_W-1:0] araddr;
        logic                       arvalid;
        logic                       rready;
    } axil_req_t;

    typedef struct packed {
        logic                       awready;
        logic                       wready;
        logic [1:0]                 bresp;
        logic                       bvalid;
        logic                       arready;
        logic [`DSP_AXI_DATA_W-1:0] rdata;
        logic [1:0]                 rresp;
        logic                       rvalid;
    } axil_rsp_t;

endpackage

// File: dsp_defs.svh
`ifndef DSP_DEFS_SVH
`define DSP_DEFS_SVH

// Datapath geometry
`define DSP_LANES      4
`define DSP_CODE_W     8
`define DSP_FFE_TAPS   3
`define DSP_WEIGHT_W   8
`define DSP_FFE_W      18
`define DSP_THRESH_W   8
`define DSP_SHIFT_W    4
`define DSP_CHAN_TAPS  3
`define DSP_CHAN_W     8
`define DSP_ERR_W      11

// AXI4-Lite register map
`define DSP_AXI_ADDR_W 4
`define DSP_AXI_DATA_W 32
`define DSP_ADDR_FFE   4'h0
`define DSP_ADDR_CTRL  4'h4
`define DSP_ADDR_CHAN  4'h8

`endif
